//--- ex_core.f
logic/ex_pkg.sv
logic/ex_ctrl.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_stage_top.sv
verification/ex_tb_clk.sv
verification/ex_stage_assert.sv
verification/ex_tb.sv

//--- logic/ex_alu.sv
// Combinational ALU with result select and branch comparator
`timescale 1ns/1ps

module ex_alu (
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  input  ex_pkg::alu_op_e         alu_op_i,
  input  ex_pkg::br_cond_e        br_cond_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    cmp_o
);

  logic eq;
  logic lt_s;
  logic lt_u;

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  // Shared compare results for SLT, SLTU and the branch condition
  assign eq   = (op_a_i == op_b_i);
  assign lt_s = ($signed(op_a_i) < $signed(op_b_i));
  assign lt_u = (op_a_i < op_b_i);

  // Branch condition picked by the decoded condition field
  always_comb begin
    unique case (br_cond_i)
      ex_pkg::BR_EQ: cmp_o = eq;
      ex_pkg::BR_NE: cmp_o = !eq;
      ex_pkg::BR_LT: cmp_o = lt_s;
      ex_pkg::BR_GE: cmp_o = !lt_s;
      default:       cmp_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  // Set-less-than results are zero extended to the full width
  always_comb begin
    unique case (alu_op_i)
      ex_pkg::ALU_ADD: begin
        result_o = op_a_i + op_b_i;
      end
      ex_pkg::ALU_SUB: begin
        result_o = op_a_i - op_b_i;
      end
      ex_pkg::ALU_AND: begin
        result_o = op_a_i & op_b_i;
      end
      ex_pkg::ALU_OR: begin
        result_o = op_a_i | op_b_i;
      end
      ex_pkg::ALU_XOR: begin
        result_o = op_a_i ^ op_b_i;
      end
      ex_pkg::ALU_SLT: begin
        result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
      end
      ex_pkg::ALU_SLTU: begin
        result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
      end
      // Unused encoding gives zero
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

//--- logic/ex_branch.sv
// Branch decision and target computation with data-independent timing mode
`timescale 1ns/1ps

module ex_branch (
  input  logic [ex_pkg::XLEN-1:0] pc_i,
  input  logic [ex_pkg::XLEN-1:0] imm_i,
  input  logic                    is_branch_i,
  input  logic                    compressed_i,
  input  logic                    cmp_i,
  input  logic                    dataind_i,
  output logic                    branch_taken_o,
  output logic [ex_pkg::XLEN-1:0] branch_target_o
);

  logic [ex_pkg::XLEN-1:0] target_jump;
  logic [ex_pkg::XLEN-1:0] target_seq;
  logic [ex_pkg::XLEN-1:0] instr_len;

  ////////////////////////////////////////
  // Target addresses
  ////////////////////////////////////////

  // Regular branch target relative to the branch itself
  assign target_jump = pc_i + imm_i;

  // Compressed instructions are two bytes, everything else four
  assign instr_len  = compressed_i ? ex_pkg::XLEN'(2) : ex_pkg::XLEN'(4);
  assign target_seq = pc_i + instr_len;

  ////////////////////////////////////////
  // Decision
  ////////////////////////////////////////

  // In data-independent mode every branch redirects the fetch
  // A failed condition then just jumps to the next instruction
  // so both outcomes cost the same number of cycles
  always_comb begin
    if (dataind_i) begin
      branch_taken_o  = is_branch_i;
      branch_target_o = cmp_i ? target_jump : target_seq;
    end else begin
      branch_taken_o  = is_branch_i && cmp_i;
      branch_target_o = target_jump;
    end
  end

endmodule

//--- logic/ex_ctrl.sv
// Execute stage control with instruction register, valid flag, handshake and write enables
`timescale 1ns/1ps

module ex_ctrl (
  input  logic                                clk,
  input  logic                                arst_n_i,

  // Decode side
  input  logic                                id_valid_i,
  output logic                                ex_ready_o,
  input  logic [ex_pkg::XLEN-1:0]             pc_i,
  input  logic [ex_pkg::XLEN-1:0]             op_a_i,
  input  logic [ex_pkg::XLEN-1:0]             op_b_i,
  input  logic [ex_pkg::XLEN-1:0]             imm_i,
  input  ex_pkg::alu_op_e                     alu_op_i,
  input  logic                                is_branch_i,
  input  ex_pkg::br_cond_e                    br_cond_i,
  input  logic                                compressed_i,
  input  logic                                rf_we_i,
  input  logic                                csr_en_i,
  input  logic [ex_pkg::CSR_ADDR_W-1:0]       csr_addr_i,
  input  logic                                lsu_en_i,
  input  logic                                lsu_split_i,
  input  logic                                xif_accepted_i,

  // Controller side
  input  logic                                halt_i,
  input  logic                                kill_i,

  // Write-back side
  input  logic                                wb_ready_i,
  output logic                                ex_valid_o,
  output logic                                rf_we_o,
  output logic                                csr_en_o,

  // Held fields for the ALU and branch unit
  output logic [ex_pkg::XLEN-1:0]             pc_o,
  output logic [ex_pkg::XLEN-1:0]             op_a_o,
  output logic [ex_pkg::XLEN-1:0]             op_b_o,
  output logic [ex_pkg::XLEN-1:0]             imm_o,
  output ex_pkg::alu_op_e                     alu_op_o,
  output logic                                is_branch_o,
  output ex_pkg::br_cond_e                    br_cond_o,
  output logic                                compressed_o
);

  logic                          valid_q;
  logic                          accept;
  logic                          handoff;
  logic                          is_branch_q;
  logic                          rf_we_q;
  logic                          csr_en_q;
  logic [ex_pkg::CSR_ADDR_W-1:0] csr_addr_q;
  logic                          lsu_en_q;
  logic                          lsu_split_q;
  logic                          xif_accepted_q;
  logic                          csr_legal;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Kill always frees the stage while halt freezes it unless a kill overrides
  assign ex_ready_o = kill_i || (!halt_i && (!valid_q || wb_ready_i));
  assign ex_valid_o = valid_q && !halt_i && !kill_i;

  assign accept  = id_valid_i && ex_ready_o;
  assign handoff = ex_valid_o && wb_ready_i;

  // A new instruction wins over handoff and kill because the old one is gone either way
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (kill_i || handoff) begin
      valid_q <= 1'b0;
    end
  end

  // Instruction register that only loads on an accepted handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_o           <= pc_i;
      op_a_o         <= op_a_i;
      op_b_o         <= op_b_i;
      imm_o          <= imm_i;
      alu_op_o       <= alu_op_i;
      is_branch_q    <= is_branch_i;
      br_cond_o      <= br_cond_i;
      compressed_o   <= compressed_i;
      rf_we_q        <= rf_we_i;
      csr_en_q       <= csr_en_i;
      csr_addr_q     <= csr_addr_i;
      lsu_en_q       <= lsu_en_i;
      lsu_split_q    <= lsu_split_i;
      xif_accepted_q <= xif_accepted_i;
    end
  end

  ////////////////////////////////////////
  // Write enable qualification
  ////////////////////////////////////////

  // The branch unit only sees a branch while the stage presents it
  assign is_branch_o = is_branch_q && ex_valid_o;

  // CSR address must fall inside the implemented window
  assign csr_legal = (csr_addr_q >= ex_pkg::CSR_IMPL_LO) && (csr_addr_q <= ex_pkg::CSR_IMPL_HI);

  // First half of a split load or store never reaches the register file
  assign rf_we_o = valid_q && rf_we_q && !(lsu_en_q && lsu_split_q);

  // Illegal CSR or a coprocessor that took the instruction blocks the CSR write
  assign csr_en_o = valid_q && csr_en_q && csr_legal && !xif_accepted_q;

endmodule

//--- logic/ex_pkg.sv
// Execute stage package with widths, ALU and branch encodings and the implemented CSR range
package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data path and address width of the core
  localparam int unsigned XLEN = 32;

  // Width of a CSR address as found in the instruction
  localparam int unsigned CSR_ADDR_W = 12;

  ////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////

  // Lowest and highest CSR address that the CSR file implements
  // Anything outside this window is treated as an illegal CSR access
  localparam logic [CSR_ADDR_W-1:0] CSR_IMPL_LO = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_IMPL_HI = 12'h3ff;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // ALU operation selected by decode
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLT  = 3'd5,
    ALU_SLTU = 3'd6
  } alu_op_e;

  // Condition of a conditional branch where LT and GE compare signed
  typedef enum logic [1:0] {
    BR_EQ = 2'd0,
    BR_NE = 2'd1,
    BR_LT = 2'd2,
    BR_GE = 2'd3
  } br_cond_e;

endpackage

//--- logic/ex_stage_top.sv
// Execute stage top level connecting control, ALU and branch unit
`timescale 1ns/1ps

module ex_stage_top (
  input  logic                          clk,
  input  logic                          arst_n_i,

  // Decode side
  input  logic                          id_valid_i,
  output logic                          ex_ready_o,
  input  logic [ex_pkg::XLEN-1:0]       pc_i,
  input  logic [ex_pkg::XLEN-1:0]       op_a_i,
  input  logic [ex_pkg::XLEN-1:0]       op_b_i,
  input  logic [ex_pkg::XLEN-1:0]       imm_i,
  input  ex_pkg::alu_op_e               alu_op_i,
  input  logic                          is_branch_i,
  input  ex_pkg::br_cond_e              br_cond_i,
  input  logic                          compressed_i,
  input  logic                          rf_we_i,
  input  logic                          csr_en_i,
  input  logic [ex_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic                          lsu_en_i,
  input  logic                          lsu_split_i,
  input  logic                          xif_accepted_i,

  // Controller side
  input  logic                          halt_i,
  input  logic                          kill_i,
  input  logic                          dataind_i,

  // Write-back side
  input  logic                          wb_ready_i,
  output logic                          ex_valid_o,
  output logic [ex_pkg::XLEN-1:0]       result_o,
  output logic                          rf_we_o,
  output logic                          csr_en_o,

  // Branch outputs towards fetch
  output logic                          branch_taken_o,
  output logic [ex_pkg::XLEN-1:0]       branch_target_o
);

  // Held instruction fields from the control block
  logic [ex_pkg::XLEN-1:0] pc_q;
  logic [ex_pkg::XLEN-1:0] op_a_q;
  logic [ex_pkg::XLEN-1:0] op_b_q;
  logic [ex_pkg::XLEN-1:0] imm_q;
  ex_pkg::alu_op_e         alu_op_q;
  ex_pkg::br_cond_e        br_cond_q;
  logic                    is_branch_v;
  logic                    compressed_q;
  logic                    alu_cmp;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  ex_ctrl i_ex_ctrl (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .id_valid_i     (id_valid_i),
    .ex_ready_o     (ex_ready_o),
    .pc_i           (pc_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .imm_i          (imm_i),
    .alu_op_i       (alu_op_i),
    .is_branch_i    (is_branch_i),
    .br_cond_i      (br_cond_i),
    .compressed_i   (compressed_i),
    .rf_we_i        (rf_we_i),
    .csr_en_i       (csr_en_i),
    .csr_addr_i     (csr_addr_i),
    .lsu_en_i       (lsu_en_i),
    .lsu_split_i    (lsu_split_i),
    .xif_accepted_i (xif_accepted_i),
    .halt_i         (halt_i),
    .kill_i         (kill_i),
    .wb_ready_i     (wb_ready_i),
    .ex_valid_o     (ex_valid_o),
    .rf_we_o        (rf_we_o),
    .csr_en_o       (csr_en_o),
    .pc_o           (pc_q),
    .op_a_o         (op_a_q),
    .op_b_o         (op_b_q),
    .imm_o          (imm_q),
    .alu_op_o       (alu_op_q),
    .is_branch_o    (is_branch_v),
    .br_cond_o      (br_cond_q),
    .compressed_o   (compressed_q)
  );

  // ALU also produces the branch compare
  ex_alu i_ex_alu (
    .op_a_i    (op_a_q),
    .op_b_i    (op_b_q),
    .alu_op_i  (alu_op_q),
    .br_cond_i (br_cond_q),
    .result_o  (result_o),
    .cmp_o     (alu_cmp)
  );

  // Branch flag is already gated with the stage valid
  ex_branch i_ex_branch (
    .pc_i            (pc_q),
    .imm_i           (imm_q),
    .is_branch_i     (is_branch_v),
    .compressed_i    (compressed_q),
    .cmp_i           (alu_cmp),
    .dataind_i       (dataind_i),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

endmodule

//--- verification/ex_stage_assert.sv
// Halt, kill and back-pressure assertions bound into the execute stage top level
`timescale 1ns/1ps

module ex_stage_assert (
  input logic                    clk,
  input logic                    arst_n_i,
  input logic                    halt_i,
  input logic                    kill_i,
  input logic                    id_valid_i,
  input logic                    wb_ready_i,
  input logic                    ex_ready_i,
  input logic                    ex_valid_i,
  input logic                    ex_rf_we_i,
  input logic                    ex_csr_en_i,
  input logic [ex_pkg::XLEN-1:0] ex_result_i,
  input logic [ex_pkg::XLEN-1:0] ex_target_i
);

  // Number of failed assertions that the testbench top watches
  int unsigned fail_cnt;

  initial begin
    fail_cnt = 0;
  end

  ////////////////////////////////////////
  // Halt and kill
  ////////////////////////////////////////

  // Halt alone freezes the stage in both directions
  a_halt_freeze : assert property (@(posedge clk) disable iff (!arst_n_i)
    halt_i && !kill_i |-> !ex_ready_i && !ex_valid_i)
    else begin
      $error("Halt without kill left the stage ready or valid");
      fail_cnt++;
    end

  // Kill frees the stage and hides the held instruction
  a_kill_frees : assert property (@(posedge clk) disable iff (!arst_n_i)
    kill_i |-> ex_ready_i && !ex_valid_i)
    else begin
      $error("Kill did not raise ready or did not drop valid");
      fail_cnt++;
    end

  // A killed instruction never comes back unless a new one was taken
  a_kill_drops : assert property (@(posedge clk) disable iff (!arst_n_i)
    kill_i && !id_valid_i |=> !ex_valid_i)
    else begin
      $error("A killed instruction was presented again");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // Back-pressure
  ////////////////////////////////////////

  // Write-back stall blocks decode
  a_stall_ready : assert property (@(posedge clk) disable iff (!arst_n_i)
    ex_valid_i && !wb_ready_i |-> !ex_ready_i)
    else begin
      $error("Stage accepted a new instruction while write-back stalled");
      fail_cnt++;
    end

  // Outputs towards write-back and fetch do not move during a stall
  a_stall_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
    ex_valid_i && !wb_ready_i |=> $stable(ex_result_i) && $stable(ex_target_i)
      && $stable(ex_rf_we_i) && $stable(ex_csr_en_i))
    else begin
      $error("Stage outputs changed while write-back stalled");
      fail_cnt++;
    end

endmodule

bind ex_stage_top ex_stage_assert i_ex_stage_assert (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .halt_i      (halt_i),
  .kill_i      (kill_i),
  .id_valid_i  (id_valid_i),
  .wb_ready_i  (wb_ready_i),
  .ex_ready_i  (ex_ready_o),
  .ex_valid_i  (ex_valid_o),
  .ex_rf_we_i  (rf_we_o),
  .ex_csr_en_i (csr_en_o),
  .ex_result_i (result_o),
  .ex_target_i (branch_target_o)
);

//--- verification/ex_tb.sv
// Execute stage testbench top with stimulus, reference model and output checks
`timescale 1ns/1ps

module ex_tb;

  // Cycles that any handshake wait may take
  localparam int unsigned TIMEOUT_CYCLES = 20;

  logic clk;
  logic arst_n;
  logic id_valid, halt, kill, dataind, wb_ready;
  logic [ex_pkg::XLEN-1:0] pc, op_a, op_b, imm;
  ex_pkg::alu_op_e alu_op;
  ex_pkg::br_cond_e br_cond;
  logic is_branch, compressed, rf_we, csr_en, lsu_en, lsu_split, xif_accepted;
  logic [ex_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic ex_ready, ex_valid, rf_we_out, csr_en_out, branch_taken;
  logic [ex_pkg::XLEN-1:0] result, branch_target;
  logic [31:0] rng_state;

  // Reference model of the stage that holds the expected values of the instruction in flight
  logic m_valid, m_ready, m_ex_valid;
  logic m_is_branch, m_taken, m_rf_we, m_csr_en;
  logic [ex_pkg::XLEN-1:0] m_result, m_target;

  ex_tb_clk i_ex_tb_clk (.clk_o(clk));

  ex_stage_top i_ex_stage_top (
    .clk(clk), .arst_n_i(arst_n), .id_valid_i(id_valid), .ex_ready_o(ex_ready),
    .pc_i(pc), .op_a_i(op_a), .op_b_i(op_b), .imm_i(imm), .alu_op_i(alu_op),
    .is_branch_i(is_branch), .br_cond_i(br_cond), .compressed_i(compressed),
    .rf_we_i(rf_we), .csr_en_i(csr_en), .csr_addr_i(csr_addr), .lsu_en_i(lsu_en),
    .lsu_split_i(lsu_split), .xif_accepted_i(xif_accepted), .halt_i(halt),
    .kill_i(kill), .dataind_i(dataind), .wb_ready_i(wb_ready), .ex_valid_o(ex_valid),
    .result_o(result), .rf_we_o(rf_we_out), .csr_en_o(csr_en_out),
    .branch_taken_o(branch_taken), .branch_target_o(branch_target)
  );

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  function automatic logic [ex_pkg::XLEN-1:0] alu_model(ex_pkg::alu_op_e op,
      logic [ex_pkg::XLEN-1:0] a, logic [ex_pkg::XLEN-1:0] b);
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      ex_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
      default:          return '0;
    endcase
  endfunction

  // Branch condition where LT and GE compare signed
  function automatic logic cond_holds(ex_pkg::br_cond_e cond,
      logic [ex_pkg::XLEN-1:0] a, logic [ex_pkg::XLEN-1:0] b);
    case (cond)
      ex_pkg::BR_EQ: return a == b;
      ex_pkg::BR_NE: return a != b;
      ex_pkg::BR_LT: return $signed(a) < $signed(b);
      default:       return $signed(a) >= $signed(b);
    endcase
  endfunction

  // A failed branch in data-independent mode targets its fall-through address
  function automatic logic [ex_pkg::XLEN-1:0] branch_dest(logic [ex_pkg::XLEN-1:0] p,
      logic [ex_pkg::XLEN-1:0] offs, logic comp, logic cond_ok, logic dind);
    if (dind && !cond_ok) begin
      return comp ? p + 2 : p + 4;
    end
    return p + offs;
  endfunction

  function automatic logic csr_write_allowed(logic en, logic [ex_pkg::CSR_ADDR_W-1:0] addr,
      logic xif);
    return en && !xif && addr >= ex_pkg::CSR_IMPL_LO && addr <= ex_pkg::CSR_IMPL_HI;
  endfunction

  assign m_ready    = kill || (!halt && (!m_valid || wb_ready));
  assign m_ex_valid = m_valid && !halt && !kill;

  // Expected values are fixed when decode hands over the instruction
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
    end else if (id_valid && m_ready) begin
      m_valid     <= 1'b1;
      m_result    <= alu_model(alu_op, op_a, op_b);
      m_is_branch <= is_branch;
      m_taken     <= is_branch && (dataind || cond_holds(br_cond, op_a, op_b));
      m_target    <= branch_dest(pc, imm, compressed, cond_holds(br_cond, op_a, op_b), dataind);
      m_rf_we     <= rf_we && !(lsu_en && lsu_split);
      m_csr_en    <= csr_write_allowed(csr_en, csr_addr, xif_accepted);
    end else if (kill || (m_ex_valid && wb_ready)) begin
      m_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [ex_pkg::XLEN-1:0] got,
      logic [ex_pkg::XLEN-1:0] exp);
    stop_on_error($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  a_ready : assert property (@(posedge clk) disable iff (!arst_n) ex_ready == m_ready)
    else report_mismatch("ex_ready_o", $sampled(ex_ready), $sampled(m_ready));
  a_valid : assert property (@(posedge clk) disable iff (!arst_n) ex_valid == m_ex_valid)
    else report_mismatch("ex_valid_o", $sampled(ex_valid), $sampled(m_ex_valid));
  a_result : assert property (@(posedge clk) disable iff (!arst_n)
    m_ex_valid |-> result == m_result)
    else report_mismatch("result_o", $sampled(result), $sampled(m_result));
  a_rf_we : assert property (@(posedge clk) disable iff (!arst_n)
    rf_we_out == (m_valid && m_rf_we))
    else report_mismatch("rf_we_o", $sampled(rf_we_out), $sampled(m_valid && m_rf_we));
  a_csr : assert property (@(posedge clk) disable iff (!arst_n)
    csr_en_out == (m_valid && m_csr_en))
    else report_mismatch("csr_en_o", $sampled(csr_en_out), $sampled(m_valid && m_csr_en));
  a_taken : assert property (@(posedge clk) disable iff (!arst_n)
    branch_taken == (m_ex_valid && m_taken))
    else report_mismatch("branch_taken_o", $sampled(branch_taken),
      $sampled(m_ex_valid && m_taken));
  a_target : assert property (@(posedge clk) disable iff (!arst_n)
    m_ex_valid && m_is_branch |-> branch_target == m_target)
    else report_mismatch("branch_target_o", $sampled(branch_target), $sampled(m_target));

  // Assertions bound into the DUT count their failures
  always @(negedge clk) begin
    if (i_ex_stage_top.i_ex_stage_assert.fail_cnt != 0) begin
      stop_on_error("A halt, kill or stall assertion in the execute stage failed");
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Linear congruential generator for operands
  function automatic logic [31:0] rand_word();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic clear_fields();
    pc = '0;
    op_a = '0;
    op_b = '0;
    imm = '0;
    alu_op = ex_pkg::ALU_ADD;
    br_cond = ex_pkg::BR_EQ;
    csr_addr = '0;
    is_branch = 1'b0;
    compressed = 1'b0;
    rf_we = 1'b0;
    csr_en = 1'b0;
    lsu_en = 1'b0;
    lsu_split = 1'b0;
    xif_accepted = 1'b0;
  endtask

  // Offer the current fields until the stage takes them
  task automatic send_instr();
    int unsigned cycles;
    logic        taken;
    cycles   = 0;
    taken    = 1'b0;
    id_valid = 1'b1;
    while (!taken) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_on_error("Timed out waiting for ex_ready_o to accept an instruction");
      end
      @(negedge clk);
      taken = ex_ready;
      next_cycle();
      cycles++;
    end
    id_valid = 1'b0;
  endtask

  // Wait until write-back has taken the instruction in flight
  task automatic wait_handoff();
    int unsigned cycles;
    logic        done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_on_error("Timed out waiting for write-back to take the instruction");
      end
      @(negedge clk);
      done = ex_valid && wb_ready;
      next_cycle();
      cycles++;
    end
  endtask

  initial begin
    int i;
    int j;
    rng_state = 32'he9ab_3727;
    arst_n = 1'b0;
    id_valid = 1'b0;
    halt = 1'b0;
    kill = 1'b0;
    dataind = 1'b0;
    wb_ready = 1'b1;
    clear_fields();
    repeat (3) @(posedge clk);
    #10;
    arst_n = 1'b1;
    next_cycle();

    // ALU ops with random operands where the first of each op uses equal operands
    for (i = 0; i < 7; i++) begin
      for (j = 0; j < 4; j++) begin
        clear_fields();
        alu_op = ex_pkg::alu_op_e'(i);
        op_a = rand_word();
        op_b = (j == 0) ? op_a : rand_word();
        send_instr();
        wait_handoff();
      end
    end

    // CSR legality at both window edges crossed with xif accept
    for (i = 0; i < 8; i++) begin
      clear_fields();
      csr_en = 1'b1;
      xif_accepted = i[1];
      if (i[0]) begin
        csr_addr = i[2] ? ex_pkg::CSR_IMPL_HI : ex_pkg::CSR_IMPL_LO;
      end else begin
        csr_addr = i[2] ? ex_pkg::CSR_IMPL_HI + 12'd1 : ex_pkg::CSR_IMPL_LO - 12'd1;
      end
      send_instr();
      wait_handoff();
    end

    // Every mix of register write and split LSU access
    for (i = 0; i < 8; i++) begin
      clear_fields();
      {lsu_split, lsu_en, rf_we} = i[2:0];
      send_instr();
      wait_handoff();
    end

    // Branches in normal and data-independent mode while the stage is empty at each mode change
    for (i = 0; i < 2; i++) begin
      dataind = i[0];
      for (j = 0; j < 16; j++) begin
        clear_fields();
        is_branch = 1'b1;
        br_cond = ex_pkg::br_cond_e'(j[1:0]);
        compressed = j[2];
        pc = rand_word() & ~32'h1;
        imm = rand_word() & 32'h0000_0ffe;
        op_a = rand_word();
        op_b = j[3] ? op_a : rand_word();
        send_instr();
        wait_handoff();
      end
    end
    dataind = 1'b0;

    // Write-back stall with a second instruction on offer, then halt, then halt with kill
    clear_fields();
    alu_op = ex_pkg::ALU_XOR;
    op_a = rand_word();
    op_b = rand_word();
    rf_we = 1'b1;
    wb_ready = 1'b0;
    send_instr();
    alu_op = ex_pkg::ALU_ADD;
    op_a = rand_word();
    op_b = rand_word();
    rf_we = 1'b0;
    csr_en = 1'b1;
    csr_addr = ex_pkg::CSR_IMPL_LO;
    id_valid = 1'b1;
    repeat (4) next_cycle();
    halt = 1'b1;
    repeat (2) next_cycle();
    id_valid = 1'b0;
    kill = 1'b1;
    next_cycle();
    halt = 1'b0;
    kill = 1'b0;
    wb_ready = 1'b1;
    repeat (3) next_cycle();

    // Halt right after accept and released two cycles later
    clear_fields();
    op_a = rand_word();
    send_instr();
    halt = 1'b1;
    repeat (2) next_cycle();
    halt = 1'b0;
    wait_handoff();

    // Kill and a new instruction on the same edge keep the new one
    clear_fields();
    op_b = rand_word();
    kill = 1'b1;
    send_instr();
    kill = 1'b0;
    wait_handoff();

    next_cycle();
    if (i_ex_stage_top.i_ex_stage_assert.fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_on_error("A halt, kill or stall assertion in the execute stage failed");
    end
  end

endmodule

//--- verification/ex_tb_clk.sv
// Testbench clock generator with a 100 ns period
`timescale 1ns/1ps

module ex_tb_clk (
  output logic clk_o
);

  // Start low so the first rising edge comes at 50 ns
  initial begin
    clk_o = 1'b0;
  end

  // Half period of 50 ns
  always #50 clk_o = ~clk_o;

endmodule
